// File: src/video_pkg.sv
`default_nettype none

package video_pkg;

    //////////////////////////////////////////////////
    // camera side
    //////////////////////////////////////////////////

    localparam int CAM_BYTE_W = 8;              // camera parallel bus
    localparam int PIX_W      = 16;             // two camera bytes per pixel

    typedef logic [CAM_BYTE_W-1:0] cam_byte_t;  // one byte off the sensor

    //////////////////////////////////////////////////
    // rgb565 pixel, display order
    //////////////////////////////////////////////////

    localparam int RED_W   = 5;
    localparam int GREEN_W = 6;
    localparam int BLUE_W  = 5;

    // red sits in the top bits, blue in the bottom bits
    typedef struct packed {
        logic [RED_W-1:0]   red;                // bits 15:11
        logic [GREEN_W-1:0] green;              // bits 10:5
        logic [BLUE_W-1:0]  blue;               // bits 4:0
    } rgb565_t;

    //////////////////////////////////////////////////
    // display side
    //////////////////////////////////////////////////

    localparam int CHAN_W = 8;                  // per colour channel at the output

    typedef logic [CHAN_W-1:0] chan_t;          // one widened channel

endpackage : video_pkg

`default_nettype wire

// File: src/buffer_pkg.sv
`default_nettype none

package buffer_pkg;

    //////////////////////////////////////////////////
    // pixel buffer sizing
    //////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 16;             // pixel entries
    localparam int FIFO_PTR_W = 4;              // log2 of depth, pointers wrap

    // one extra bit so a full buffer reads as FIFO_DEPTH, not zero
    typedef logic [FIFO_PTR_W:0] fifo_count_t;

endpackage : buffer_pkg

`default_nettype wire

// File: src/pixel_pack.sv
`default_nettype none

module pixel_pack
    import video_pkg::*;
(
    input  wire logic      core_clk,            // capture clock
    input  wire logic      reset_i,             // sync, active high
    input  wire cam_byte_t cam_data_i,          // raw sensor byte
    input  wire logic      cam_href_i,          // line valid level
    input  wire logic      cam_vsync_i,         // frame sync level
    output logic           pix_valid_o,         // one strobe per pixel
    output rgb565_t        pix_data_o,          // pixel in display order
    output logic           pix_sof_o            // first pixel of a frame
);

    //////////////////////////////////////////////////
    // input registers
    //////////////////////////////////////////////////

    cam_byte_t  data_q;                         // registered sensor byte
    logic       href_q;                         // registered href
    logic       vsync_q;                        // registered vsync
    logic       vsync_qq;                       // previous vsync, for edge detect

    always_ff @(posedge core_clk)
    begin
        data_q <= cam_data_i;                   // payload, no reset
        if (reset_i)
        begin
            href_q   <= 1'b0;
            vsync_q  <= 1'b0;
            vsync_qq <= 1'b0;
        end
        else
        begin
            href_q   <= cam_href_i;
            vsync_q  <= cam_vsync_i;
            vsync_qq <= vsync_q;
        end
    end

    //////////////////////////////////////////////////
    // byte pairing and colour reorder
    //////////////////////////////////////////////////

    logic             phase;                    // high once the first byte is held
    cam_byte_t        hi_byte;                  // first byte of the pair
    logic             vsync_rise;               // frame start seen this cycle
    logic             sof_pend;                 // armed until the next pixel
    logic             pair_done;                // second byte on data_q
    logic [PIX_W-1:0] cam_word;                 // pair in sensor colour order

    assign vsync_rise = vsync_q & ~vsync_qq;
    assign pair_done  = href_q & phase;
    assign cam_word   = {hi_byte, data_q};      // high byte arrives first

    always_ff @(posedge core_clk)
    begin
        if (href_q && !phase)
        begin
            hi_byte <= data_q;                  // hold until its partner shows up
        end
        if (pair_done)
        begin
            // sensor gives blue on top, display wants red on top
            pix_data_o.red   <= cam_word[4:0];
            pix_data_o.green <= cam_word[10:5];
            pix_data_o.blue  <= cam_word[15:11];
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            phase       <= 1'b0;
            sof_pend    <= 1'b0;
            pix_valid_o <= 1'b0;
            pix_sof_o   <= 1'b0;
        end
        else
        begin
            phase       <= href_q & ~phase;     // href low drops a lone byte
            pix_valid_o <= pair_done;
            pix_sof_o   <= pair_done & (sof_pend | vsync_rise);
            if (pair_done)
            begin
                sof_pend <= 1'b0;               // mark consumed by this pixel
            end
            else if (vsync_rise)
            begin
                sof_pend <= 1'b1;
            end
        end
    end

endmodule : pixel_pack

`default_nettype wire

// File: src/pixel_fifo.sv
`default_nettype none

module pixel_fifo
    import video_pkg::*;
    import buffer_pkg::*;
(
    input  wire logic    core_clk,              // single clock
    input  wire logic    reset_i,               // sync, active high
    input  wire logic    push_i,                // write strobe
    input  wire rgb565_t push_data_i,           // pixel to store
    input  wire logic    push_sof_i,            // frame start flag with it
    input  wire logic    pop_i,                 // read strobe, never while empty
    output rgb565_t      pop_data_o,            // valid cycle after pop
    output logic         pop_sof_o,             // flag for pop_data_o
    output logic         empty_o,               // nothing stored
    output logic         overflow_o             // sticky, push lost while full
);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    rgb565_t                 pix_mem [FIFO_DEPTH];  // pixel entries
    logic [FIFO_DEPTH-1:0]   sof_mem;               // one flag per entry
    logic [FIFO_PTR_W-1:0]   wr_ptr;                // next slot to write
    logic [FIFO_PTR_W-1:0]   rd_ptr;                // oldest entry
    fifo_count_t             count;                 // entries held
    logic                    full;
    logic                    push_ok;               // push that is kept
    logic                    pop_ok;                // pop with data behind it
    logic                    push_drop;             // push thrown away

    assign full    = (count == fifo_count_t'(FIFO_DEPTH));
    assign empty_o = (count == '0);                 // falls the cycle after a push

    // a pop in the same cycle frees the slot, so a full buffer still takes the push
    assign pop_ok    = pop_i & ~empty_o;
    assign push_ok   = push_i & (~full | pop_ok);
    assign push_drop = push_i & full & ~pop_ok;

    always_ff @(posedge core_clk)
    begin
        if (push_ok)
        begin
            pix_mem[wr_ptr] <= push_data_i;
            sof_mem[wr_ptr] <= push_sof_i;
        end
        if (pop_ok)
        begin
            pop_data_o <= pix_mem[rd_ptr];      // old value when wr_ptr == rd_ptr
        end
    end

    //////////////////////////////////////////////////
    // pointers, count and flags
    //////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            pop_sof_o  <= 1'b0;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;        // wraps at depth
            end
            if (pop_ok)
            begin
                rd_ptr    <= rd_ptr + 1'b1;
                pop_sof_o <= sof_mem[rd_ptr];
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
            if (push_drop)
            begin
                overflow_o <= 1'b1;             // held until reset
            end
        end
    end

endmodule : pixel_fifo

`default_nettype wire

// File: src/video_out.sv
`default_nettype none

module video_out
    import video_pkg::*;
(
    input  wire logic    core_clk,              // display clock, same domain
    input  wire logic    reset_i,               // sync, active high
    input  wire logic    out_ready_i,           // display read enable level
    input  wire logic    fifo_empty_i,          // buffer has nothing
    output logic         fifo_pop_o,            // read strobe to buffer
    input  wire rgb565_t fifo_data_i,           // read data, one cycle after pop
    input  wire logic    fifo_sof_i,            // frame start with read data
    output chan_t        red_o,                 // 8-bit red
    output chan_t        green_o,               // 8-bit green
    output chan_t        blue_o,                // 8-bit blue
    output logic         de_o,                  // channels valid
    output logic         sof_o                  // first pixel of frame
);

    //////////////////////////////////////////////////
    // buffer read
    //////////////////////////////////////////////////

    logic pop_q;                                // read data lands this cycle

    assign fifo_pop_o = out_ready_i & ~fifo_empty_i;  // only pop when data is there

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            pop_q <= 1'b0;
        end
        else
        begin
            pop_q <= fifo_pop_o;                // match buffer read latency
        end
    end

    //////////////////////////////////////////////////
    // widen rgb565 to 8 bits per channel
    //////////////////////////////////////////////////

    always_ff @(posedge core_clk)
    begin
        if (pop_q)
        begin
            // field moves to the top, low bits zero
            red_o   <= {fifo_data_i.red,   {(CHAN_W-RED_W){1'b0}}};
            green_o <= {fifo_data_i.green, {(CHAN_W-GREEN_W){1'b0}}};
            blue_o  <= {fifo_data_i.blue,  {(CHAN_W-BLUE_W){1'b0}}};
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (reset_i)
        begin
            de_o  <= 1'b0;
            sof_o <= 1'b0;
        end
        else
        begin
            de_o  <= pop_q;                     // two cycles after the pop request
            sof_o <= pop_q & fifo_sof_i;        // only qualified by a real pixel
        end
    end

endmodule : video_out

`default_nettype wire

// File: src/cam_capture_top.sv
`default_nettype none

module cam_capture_top
    import video_pkg::*;
(
    input  wire logic      core_clk,            // one clock for the whole path
    input  wire logic      reset_i,             // sync, active high
    input  wire cam_byte_t cam_data_i,          // sensor byte bus
    input  wire logic      cam_href_i,          // sensor line valid
    input  wire logic      cam_vsync_i,         // sensor frame sync
    input  wire logic      out_ready_i,         // display read enable
    output chan_t          red_o,
    output chan_t          green_o,
    output chan_t          blue_o,
    output logic           de_o,                // output pixel valid
    output logic           sof_o,               // first output pixel of frame
    output logic           overflow_o           // pixels were lost
);

    //////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////

    logic    pix_valid;                         // producer strobe
    rgb565_t pix_data;                          // producer pixel
    logic    pix_sof;                           // producer frame start
    logic    fifo_empty;
    logic    fifo_pop;
    rgb565_t fifo_data;                         // buffer read data
    logic    fifo_sof;

    // sensor bytes to rgb565 pixels
    pixel_pack u_pixel_pack (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .pix_valid_o (pix_valid),
        .pix_data_o  (pix_data),
        .pix_sof_o   (pix_sof)
    );

    // decouples capture from display reads
    pixel_fifo u_pixel_fifo (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .push_i      (pix_valid),
        .push_data_i (pix_data),
        .push_sof_i  (pix_sof),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_data),
        .pop_sof_o   (fifo_sof),
        .empty_o     (fifo_empty),
        .overflow_o  (overflow_o)
    );

    // drains on display read, widens channels
    video_out u_video_out (
        .core_clk     (core_clk),
        .reset_i      (reset_i),
        .out_ready_i  (out_ready_i),
        .fifo_empty_i (fifo_empty),
        .fifo_pop_o   (fifo_pop),
        .fifo_data_i  (fifo_data),
        .fifo_sof_i   (fifo_sof),
        .red_o        (red_o),
        .green_o      (green_o),
        .blue_o       (blue_o),
        .de_o         (de_o),
        .sof_o        (sof_o)
    );

endmodule : cam_capture_top

`default_nettype wire

// File: tests/cam_capture_assertions.sv
`default_nettype none

module fifo_protocol_checks
    import video_pkg::*;
    import buffer_pkg::*;
(
    input wire logic        core_clk,
    input wire logic        reset_i,
    input wire logic        pop_i,              // buffer read strobe
    input wire logic        empty_i,            // buffer empty flag
    input wire fifo_count_t count_i,            // buffer occupancy
    input wire logic        overflow_i          // sticky overflow flag
);

    int fail_count = 0;                         // read by the testbench at the end

    //////////////////////////////////////////////////
    // buffer protocol
    //////////////////////////////////////////////////

    // reads only with data stored
    pop_has_data: assert property (@(posedge core_clk) disable iff (reset_i)
        pop_i |-> !empty_i)
    else
    begin
        fail_count = fail_count + 1;
        $error("pop issued while the buffer is empty");
    end

    count_in_range: assert property (@(posedge core_clk) disable iff (reset_i)
        count_i <= fifo_count_t'(FIFO_DEPTH))
    else
    begin
        fail_count = fail_count + 1;
        $error("buffer occupancy above its depth");
    end

    // only a reset clears it
    overflow_sticky: assert property (@(posedge core_clk)
        (overflow_i && !reset_i) |=> overflow_i)
    else
    begin
        fail_count = fail_count + 1;
        $error("overflow flag fell without a reset");
    end

endmodule : fifo_protocol_checks

bind pixel_fifo fifo_protocol_checks fifo_checks (
    .core_clk   (core_clk),
    .reset_i    (reset_i),
    .pop_i      (pop_i),
    .empty_i    (empty_o),
    .count_i    (count),
    .overflow_i (overflow_o)
);

`default_nettype wire

// File: tests/cam_capture_tb.sv
`default_nettype none

module cam_capture_tb
    import video_pkg::*;
    import buffer_pkg::*;
();

    //////////////////////////////////////////////////
    // constants and dut signals
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD    = 4;
    localparam int DRIVE_DELAY   = 1;           // after the rising edge
    localparam int ROOM_TIMEOUT  = 200;         // cycles
    localparam int DRAIN_TIMEOUT = 400;         // cycles
    localparam int FLAG_TIMEOUT  = 20;          // cycles
    localparam int MAX_LINE      = 9;           // bytes, up to 4 pixels
    localparam int MAX_INFLIGHT  = FIFO_DEPTH - 6;  // room for one more line

    logic      core_clk;
    logic      reset_i;
    cam_byte_t cam_data_i;
    logic      cam_href_i;
    logic      cam_vsync_i;
    logic      out_ready_i;
    chan_t     red_o;
    chan_t     green_o;
    chan_t     blue_o;
    logic      de_o;
    logic      sof_o;
    logic      overflow_o;

    cam_capture_top UUT (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .cam_data_i  (cam_data_i),
        .cam_href_i  (cam_href_i),
        .cam_vsync_i (cam_vsync_i),
        .out_ready_i (out_ready_i),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .de_o        (de_o),
        .sof_o       (sof_o),
        .overflow_o  (overflow_o)
    );

    //////////////////////////////////////////////////
    // reference model state
    //////////////////////////////////////////////////

    integer         seed = 32'hd027a669;
    logic [PIX_W:0] exp_q [$];                  // {sof, pair in sensor colour order}
    logic [PIX_W:0] exp_entry;                  // entry under check
    logic [31:0]    exp_word;                   // sensor word of that entry
    logic           phase_m;                    // first byte of a pair held
    cam_byte_t      first_m;                    // high byte of the pair
    logic           sof_armed;                  // vsync rose, next pixel is sof
    logic           vsync_prev;
    int             ready_mode;                 // 0 low, 1 high, 2 random
    logic           flood;                      // display stalled, buffer may fill
    int             flood_occ;                  // pixels held since drain
    int             dropped;                    // pixels lost to a full buffer
    logic           overflow_allowed;
    logic           monitor_on;

    initial
    begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'($unsigned(r) % (hi - lo + 1));
    endfunction

    // pairing rules applied to what goes onto the camera pins
    task automatic model_inputs(input logic href, input cam_byte_t data, input logic vsync);
        logic [PIX_W-1:0] word;
        if (vsync && !vsync_prev)
        begin
            sof_armed = 1'b1;                   // marks the next pixel formed
        end
        vsync_prev = vsync;
        if (!href)
        begin
            phase_m = 1'b0;                     // lone byte is lost
        end
        else if (!phase_m)
        begin
            first_m = data;
            phase_m = 1'b1;
        end
        else
        begin
            word    = {first_m, data};          // first byte is the high byte
            phase_m = 1'b0;
            if (flood && flood_occ >= FIFO_DEPTH)
            begin
                dropped = dropped + 1;          // buffer full, pixel gone
            end
            else
            begin
                exp_q.push_back({sof_armed, word});
                if (flood)
                begin
                    flood_occ = flood_occ + 1;
                end
            end
            sof_armed = 1'b0;
        end
    endtask

    task automatic drive_cycle(input logic href, input logic vsync);
        cam_byte_t data;
        data = cam_byte_t'($random(seed));
        @(posedge core_clk);
        #DRIVE_DELAY;
        cam_data_i  = data;
        cam_href_i  = href;
        cam_vsync_i = vsync;
        case (ready_mode)
            0:       out_ready_i = 1'b0;
            1:       out_ready_i = 1'b1;
            default: out_ready_i = rand_range(0, 1);
        endcase
        model_inputs(href, data, vsync);
    endtask

    task automatic send_line(input int len);
        repeat (len) drive_cycle(1'b1, 1'b0);
        repeat (rand_range(1, 3)) drive_cycle(1'b0, 1'b0);  // href gap
    endtask

    task automatic vsync_pulse();
        drive_cycle(1'b0, 1'b1);
        drive_cycle(1'b0, 1'b1);
        drive_cycle(1'b0, 1'b0);
    endtask

    task automatic wait_for_room();
        int waited;
        waited = 0;
        while (exp_q.size() > MAX_INFLIGHT)
        begin
            drive_cycle(1'b0, 1'b0);
            waited = waited + 1;
            if (waited > ROOM_TIMEOUT)
            begin
                abort_run("timeout: outstanding pixels never dropped enough for a new line");
            end
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            drive_cycle(1'b0, 1'b0);
            waited = waited + 1;
            if (waited > DRAIN_TIMEOUT)
            begin
                abort_run("timeout: expected pixels never reached the display output");
            end
        end
    endtask

    task automatic wait_for_overflow();
        int waited;
        waited = 0;
        while (overflow_o !== 1'b1)
        begin
            drive_cycle(1'b0, 1'b0);
            waited = waited + 1;
            if (waited > FLAG_TIMEOUT)
            begin
                abort_run("timeout: overflow flag never rose after the buffer filled up");
            end
        end
    endtask

    //////////////////////////////////////////////////
    // output monitor, sampled mid cycle
    //////////////////////////////////////////////////

    always @(negedge core_clk)
    begin
        if (monitor_on)
        begin
            if (!overflow_allowed)
            begin
                compare_value("overflow_o", overflow_o, 32'h0);
            end
            if (de_o)
            begin
                if (exp_q.size() == 0)
                begin
                    abort_run("output pixel appeared while no pixel was expected");
                end
                else
                begin
                    exp_entry = exp_q.pop_front();
                    exp_word  = exp_entry[PIX_W-1:0];
                    // low sensor field is red, top one blue, each moved to the channel top
                    compare_value("red_o", red_o,
                                  (exp_word & ((1 << RED_W) - 1)) << (CHAN_W - RED_W));
                    compare_value("green_o", green_o,
                                  ((exp_word >> RED_W) & ((1 << GREEN_W) - 1))
                                  << (CHAN_W - GREEN_W));
                    compare_value("blue_o", blue_o,
                                  (exp_word >> (RED_W + GREEN_W)) << (CHAN_W - BLUE_W));
                    compare_value("sof_o", sof_o, exp_entry[PIX_W]);
                end
            end
            else
            begin
                compare_value("sof_o", sof_o, 32'h0);   // no sof without a pixel
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial
    begin
        reset_i          = 1'b1;
        cam_data_i       = '0;
        cam_href_i       = 1'b0;
        cam_vsync_i      = 1'b0;
        out_ready_i      = 1'b0;
        phase_m          = 1'b0;
        first_m          = '0;
        sof_armed        = 1'b0;
        vsync_prev       = 1'b0;
        ready_mode       = 1;
        flood            = 1'b0;
        flood_occ        = 0;
        dropped          = 0;
        overflow_allowed = 1'b0;
        monitor_on       = 1'b0;
        repeat (2) @(posedge core_clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        @(negedge core_clk);
        compare_value("de_o", de_o, 32'h0);             // quiet after reset
        compare_value("sof_o", sof_o, 32'h0);
        compare_value("overflow_o", overflow_o, 32'h0);
        monitor_on = 1'b1;

        // even lines, display always reading
        vsync_pulse();
        repeat (12)
        begin
            wait_for_room();
            send_line(2 * rand_range(1, MAX_LINE / 2));
        end
        drain_outputs();

        // odd lengths lose their last byte
        vsync_pulse();
        repeat (16)
        begin
            wait_for_room();
            send_line(rand_range(1, MAX_LINE));
        end
        drain_outputs();

        // short frames, one sof each
        repeat (4)
        begin
            vsync_pulse();
            repeat (rand_range(1, 3))
            begin
                wait_for_room();
                send_line(rand_range(2, MAX_LINE));
            end
        end
        drain_outputs();

        // display reads at random
        ready_mode = 2;
        repeat (3)
        begin
            vsync_pulse();
            repeat (8)
            begin
                wait_for_room();
                send_line(rand_range(1, MAX_LINE));
            end
        end
        ready_mode = 1;
        drain_outputs();

        // display stalled, buffer overflows
        ready_mode       = 0;
        flood            = 1'b1;
        flood_occ        = 0;
        dropped          = 0;
        overflow_allowed = 1'b1;
        vsync_pulse();
        while (flood_occ + dropped <= FIFO_DEPTH + 2)
        begin
            send_line(rand_range(4, MAX_LINE));
        end
        wait_for_overflow();
        ready_mode = 1;
        flood      = 1'b0;
        drain_outputs();
        repeat (8) drive_cycle(1'b0, 1'b0);     // any extra pixel trips the monitor
        compare_value("overflow_o", overflow_o, 32'h1);

        monitor_on = 1'b0;
        if (UUT.u_pixel_fifo.fifo_checks.fail_count == 0)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            abort_run("buffer protocol assertions reported failures");
        end
    end

endmodule : cam_capture_tb

`default_nettype wire

// File: compile.f
src/video_pkg.sv
src/buffer_pkg.sv
src/pixel_pack.sv
src/pixel_fifo.sv
src/video_out.sv
src/cam_capture_top.sv
tests/cam_capture_assertions.sv
tests/cam_capture_tb.sv
